// ==== src.f ====
+incdir+rtl
rtl/aes_dec_pkg.sv
rtl/aes_round_if.sv
rtl/aes_dec_decode.sv
rtl/aes_inv_sbox_serial.sv
rtl/aes_dec_execute.sv
rtl/aes_dec_result.sv
rtl/aes_dec_top.sv
dv/aes_dec_props.sv
dv/aes_dec_checker.sv
dv/aes_dec_tb.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = aes_dec_tb
FILELIST  = src.f
OBJ_DIR   = obj_dir
LOG       = sim.log
RUN_ARGS  = +verilator+error+limit+1000

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q '\*\* FAIL \*\*' $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q '\*\* PASS \*\*' $(LOG); then echo "Simulation did not finish"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== dv/aes_dec_stim.txt ====
// Lines 1-15: round keys 0..14 as 128-bit hex words
// Then one line per test: ciphertext, expected plaintext, back-pressure flag
000102030405060708090a0b0c0d0e0f
101112131415161718191a1b1c1d1e1f
a573c29fa176c498a97fce93a572c09c
1651a8cd0244beda1a5da4c10640bade
ae87dff00ff11b68a68ed5fb03fc1567
6de1f1486fa54f9275f8eb5373b8518d
c656827fc9a799176f294cec6cd5598b
3de23a75524775e727bf9eb45407cf39
0bdc905fc27b0948ad5245a4c1871c2f
45f5a66017b2d387300d4d33640a820a
7ccff71cbeb4fe5413e6bbf0d261a7df
f01afafee7a82979d7a5644ab3afe640
2541fe719bf500258813bbd55a721c0a
4e5a6699a9f24fe07e572baacdf8cdea
24fc79ccbf0979e9371ac23c6d68de36
8ea2b7ca516745bfeafc49904b496089 00112233445566778899aabbccddeeff 0
8ea2b7ca516745bfeafc49904b496089 00112233445566778899aabbccddeeff 0
8ea2b7ca516745bfeafc49904b496089 00112233445566778899aabbccddeeff 1
8ea2b7ca516745bfeafc49904b496089 00112233445566778899aabbccddeeff 1
8ea2b7ca516745bfeafc49904b496089 00112233445566778899aabbccddeeff 0

// ==== dv/aes_dec_tb.sv ====
//####################################################################
// AES-256 decoder testbench with file stimulus, key lookup and timeout
//####################################################################
`timescale 1ns/1ns
`include "aes_dec_config.svh"

module aes_dec_tb;

    localparam int bw = `AES_DEC_BYTES * 8;
    localparam int nkeys = `AES_DEC_ROUNDS + 1;
    localparam int max_tests = 32;
    localparam int reset_cycles = 3;

    logic clk;
    logic resetn;
    logic in_valid;
    logic in_ready;
    logic [bw-1:0] in_data;
    logic out_valid;
    logic out_ready = 1'b1;
    logic [bw-1:0] out_data;
    logic [`AES_DEC_KADDR_W-1:0] key_addr;
    logic [bw-1:0] round_key;
    // Plaintext handed to the checker with each block
    logic [bw-1:0] exp_data;

    logic [bw-1:0] keys [0:nkeys-1];
    logic [bw-1:0] ct_mem [0:max_tests-1];
    logic [bw-1:0] pt_mem [0:max_tests-1];
    bit bp_mem [0:max_tests-1];
    int num_tests = 0;
    int n_done;
    int n_pass;
    int n_fail;
    int seed;
    int rnd_val;
    int cycles = 0;
    int limit = 100000;

    // Key store answers in the same cycle
    assign round_key = keys[key_addr];

    aes_dec_top dut
    (
        .clk       (clk),
        .resetn    (resetn),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (in_data),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data),
        .key_addr  (key_addr),
        .round_key (round_key)
    );

    aes_dec_checker u_checker
    (
        .clk       (clk),
        .resetn    (resetn),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .exp_data  (exp_data),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data),
        .key_addr  (key_addr),
        .n_done    (n_done),
        .n_pass    (n_pass),
        .n_fail    (n_fail)
    );

    bind aes_dec_top aes_dec_props u_props
    (
        .clk       (clk),
        .resetn    (resetn),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .commit    (commit),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data),
        .key_addr  (key_addr)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Keys first then one ciphertext, plaintext and flag per line
    task automatic read_stim_file();
        int fd;
        int rc;
        int flag;
        int nk;
        string line;
        logic [bw-1:0] a;
        logic [bw-1:0] b;
        nk = 0;
        fd = $fopen("dv/aes_dec_stim.txt", "r");
        if (fd == 0)
        begin
            $display("Cannot open stimulus file dv/aes_dec_stim.txt, no tests were read");
        end
        else
        begin
            while (!$feof(fd))
            begin
                line = "";
                rc = $fgets(line, fd);
                if (rc > 1 && line.substr(0, 1) != "//")
                begin
                    if (nk < nkeys)
                    begin
                        rc = $sscanf(line, "%h", a);
                        keys[nk] = a;
                        nk++;
                    end
                    else if (num_tests < max_tests)
                    begin
                        rc = $sscanf(line, "%h %h %h", a, b, flag);
                        ct_mem[num_tests] = a;
                        pt_mem[num_tests] = b;
                        bp_mem[num_tests] = (flag != 0);
                        num_tests++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // Present one block and hold it until accepted
    task automatic send_block(input int idx);
        @(negedge clk);
        in_valid = 1'b1;
        in_data = ct_mem[idx];
        exp_data = pt_mem[idx];
        @(posedge clk);
        while (!in_ready)
            @(posedge clk);
    endtask

    // Random stalls only while a flagged block is next out
    always @(negedge clk)
    begin
        rnd_val = $random(seed);
        if (n_done < num_tests && bp_mem[n_done])
            out_ready = rnd_val[0];
        else
            out_ready = 1'b1;
    end

    always @(posedge clk)
    begin
        cycles++;
        if (cycles >= limit)
        begin
            $display("Timeout after %0d cycles with %0d of %0d blocks returned",
                     cycles, n_done, num_tests);
            $display("** FAIL **");
            $finish;
        end
    end

    initial
    begin
        seed = 32'hbab5;
        resetn = 1'b0;
        in_valid = 1'b0;
        in_data = '0;
        exp_data = '0;
        read_stim_file();
        // At most about 290 cycles per block plus reset and slack
        limit = num_tests * 300 + reset_cycles + 100;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;
        @(negedge clk);
        for (int i = 0; i < num_tests; i++)
            send_block(i);
        @(negedge clk);
        in_valid = 1'b0;
        while (n_done < num_tests)
            @(negedge clk);
        // Room for any stray extra output
        repeat (10) @(negedge clk);
        $display("Checks: %0d passed, %0d failed, %0d assertion failures",
                 n_pass, n_fail, dut.u_props.n_fail);
        if (num_tests > 0 && n_fail == 0 && n_pass == num_tests + 1 && dut.u_props.n_fail == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

// ==== dv/aes_dec_checker.sv ====
//####################################################################
// Result and key-address sequence checking with per-test reporting
//####################################################################
`timescale 1ns/1ns
`include "aes_dec_config.svh"

module aes_dec_checker
(
    input  logic                        clk,
    input  logic                        resetn,
    input  logic                        in_valid,
    input  logic                        in_ready,
    input  logic [`AES_DEC_BYTES*8-1:0] exp_data,
    input  logic                        out_valid,
    input  logic                        out_ready,
    input  logic [`AES_DEC_BYTES*8-1:0] out_data,
    input  logic [`AES_DEC_KADDR_W-1:0] key_addr,
    output int                          n_done,
    output int                          n_pass,
    output int                          n_fail
);

    // Expected plaintexts in send order
    logic [`AES_DEC_BYTES*8-1:0] exp_q[$];
    logic [`AES_DEC_BYTES*8-1:0] exp_head;
    // Key sequence verdict per committed block
    bit seq_q[$];
    bit seq_ok;
    bit seq_bad;
    bit reset_checked;
    bit tracking;
    int next_ka;
    logic [`AES_DEC_KADDR_W-1:0] prev_ka;

    initial
    begin
        n_done = 0;
        n_pass = 0;
        n_fail = 0;
        reset_checked = 1'b0;
        tracking = 1'b0;
        seq_bad = 1'b0;
        next_ka = 0;
        prev_ka = '0;
    end

    // All samples taken on the rising edge, before the DUT updates
    always @(posedge clk)
    begin
        if (resetn)
        begin
            // First edge out of reset
            if (!reset_checked)
            begin
                reset_checked = 1'b1;
                if (out_valid !== 1'b0 || in_ready !== 1'b1 || key_addr !== `AES_DEC_ROUNDS)
                begin
                    $display("Fail reset state: out_valid %h in_ready %h key_addr %h",
                             out_valid, in_ready, key_addr);
                    n_fail++;
                end
                else
                begin
                    $display("Test reset state: pass");
                    n_pass++;
                end
            end
            // in_ready back high means the block was committed
            if (tracking && in_ready)
            begin
                tracking = 1'b0;
                if (next_ka != -1)
                    $display("Key requests stopped early, key %0d was never requested",
                             next_ka);
                seq_q.push_back(!seq_bad && next_ka == -1);
            end
            else if (tracking && key_addr != prev_ka)
            begin
                if (key_addr == next_ka[`AES_DEC_KADDR_W-1:0])
                    next_ka--;
                else
                begin
                    $display("Fail key_addr: expected %h actual %h",
                             next_ka[`AES_DEC_KADDR_W-1:0], key_addr);
                    seq_bad = 1'b1;
                end
            end
            // Accept, key 14 goes with the load
            if (in_valid && in_ready)
            begin
                exp_q.push_back(exp_data);
                tracking = 1'b1;
                seq_bad = 1'b0;
                next_ka = `AES_DEC_ROUNDS - 1;
            end
            if (out_valid && out_ready)
            begin
                if (exp_q.size() == 0)
                begin
                    $display("Output block delivered with no block outstanding");
                    n_fail++;
                end
                else
                begin
                    exp_head = exp_q.pop_front();
                    seq_ok = (seq_q.size() > 0) ? seq_q.pop_front() : 1'b0;
                    n_done++;
                    if (out_data !== exp_head)
                    begin
                        $display("Fail out_data test %0d: expected %h actual %h",
                                 n_done, exp_head, out_data);
                        n_fail++;
                    end
                    else if (!seq_ok)
                    begin
                        $display("Test %0d: data correct but key sequence wrong", n_done);
                        n_fail++;
                    end
                    else
                    begin
                        $display("Test %0d: pass, out_data %h", n_done, out_data);
                        n_pass++;
                    end
                end
            end
            prev_ka = key_addr;
        end
    end

endmodule

// ==== dv/aes_dec_props.sv ====
//####################################################################
// Bound assertions on output hold, key range and input busy window
//####################################################################
`timescale 1ns/1ns
`include "aes_dec_config.svh"

module aes_dec_props
(
    input logic                        clk,
    input logic                        resetn,
    input logic                        in_valid,
    input logic                        in_ready,
    input logic                        commit,
    input logic                        out_valid,
    input logic                        out_ready,
    input logic [`AES_DEC_BYTES*8-1:0] out_data,
    input logic [`AES_DEC_KADDR_W-1:0] key_addr
);

    // Failed assertion count, read by the testbench
    int n_fail = 0;
    // Block accepted and not yet committed
    logic busy;

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
            busy <= 1'b0;
        else if (in_valid && in_ready)
            busy <= 1'b1;
        else if (commit)
            busy <= 1'b0;
    end

    // Held output stays put until taken
    a_out_hold: assert property (@(posedge clk) disable iff (!resetn)
        out_valid && !out_ready |=> out_valid && $stable(out_data))
    else
    begin
        $error("out_valid or out_data changed while waiting for out_ready");
        n_fail++;
    end

    a_key_range: assert property (@(posedge clk) disable iff (!resetn)
        key_addr <= `AES_DEC_ROUNDS)
    else
    begin
        $error("key_addr above the last round key");
        n_fail++;
    end

    // No second block while one is in flight
    a_busy_ready: assert property (@(posedge clk) disable iff (!resetn)
        busy |-> !in_ready)
    else
    begin
        $error("in_ready high while a block is being decrypted");
        n_fail++;
    end

endmodule

// ==== rtl/aes_dec_top.sv ====
//####################################################################
// AES-256 decryption core top with sequencer, datapath and result
//####################################################################
`timescale 1ns/1ns
`include "aes_dec_config.svh"

module aes_dec_top
(
    input  logic                        clk,
    input  logic                        resetn,
    input  logic                        in_valid,
    output logic                        in_ready,
    input  logic [`AES_DEC_BYTES*8-1:0] in_data,
    output logic                        out_valid,
    input  logic                        out_ready,
    output logic [`AES_DEC_BYTES*8-1:0] out_data,
    output logic [`AES_DEC_KADDR_W-1:0] key_addr,
    input  logic [`AES_DEC_BYTES*8-1:0] round_key
);

    import aes_dec_pkg::*;

    // Datapath state towards result
    state_t exec_state;
    logic commit;
    logic full;

    aes_round_if rnd ();

    aes_dec_decode u_decode
    (
        .clk      (clk),
        .resetn   (resetn),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .key_addr (key_addr),
        .full     (full),
        .commit   (commit),
        .rnd      (rnd.sequencer)
    );

    aes_dec_execute u_execute
    (
        .clk       (clk),
        .resetn    (resetn),
        .in_data   (in_data),
        .round_key (round_key),
        .state     (exec_state),
        .rnd       (rnd.datapath)
    );

    aes_dec_result u_result
    (
        .clk       (clk),
        .resetn    (resetn),
        .commit    (commit),
        .state     (exec_state),
        .full      (full),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data)
    );

endmodule

// ==== rtl/aes_dec_result.sv ====
//####################################################################
// Output block register with valid/ready handshake
//####################################################################
`timescale 1ns/1ns

module aes_dec_result
(
    input  logic                clk,
    input  logic                resetn,
    input  logic                commit,
    input  aes_dec_pkg::state_t state,
    output logic                full,
    output logic                out_valid,
    input  logic                out_ready,
    output aes_dec_pkg::state_t out_data
);

    import aes_dec_pkg::*;

    // Decode only commits when empty
    assign full = out_valid;

    always_ff @(posedge clk)
    begin
        if (commit)
            out_data <= state;
    end

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
            out_valid <= 1'b0;
        else if (commit)
            out_valid <= 1'b1;
        else if (out_ready)
            out_valid <= 1'b0;
    end

endmodule

// ==== rtl/aes_dec_execute.sv ====
//####################################################################
// Round datapath with inverse shift rows, add round key and inverse mix columns
//####################################################################
`timescale 1ns/1ns
`include "aes_dec_config.svh"

module aes_dec_execute
(
    input  logic                clk,
    input  logic                resetn,
    input  aes_dec_pkg::state_t in_data,
    input  aes_dec_pkg::state_t round_key,
    output aes_dec_pkg::state_t state,
    aes_round_if.datapath       rnd
);

    import aes_dec_pkg::*;

    localparam int idx_w = $clog2(`AES_DEC_BYTES);

    logic start;
    logic [idx_w-1:0] rd_idx;
    logic [idx_w-1:0] wr_idx;
    byte_t sbox_out;
    logic sbox_valid;
    logic sbox_done;
    state_t keyed;

    // Row r rotates right by r columns
    function automatic state_t inv_shift_rows(input state_t s);
        state_t r;
        for (int c = 0; c < 4; c++)
            for (int row = 0; row < 4; row++)
                r[4*c + row] = s[4*((c - row + 4) % 4) + row];
        return r;
    endfunction

    function automatic byte_t xtime(input byte_t b);
        return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
    endfunction

    // GF(2^8) product with a small constant, shift and add
    function automatic byte_t gf_mul(input byte_t b, input logic [3:0] m);
        byte_t acc;
        byte_t p;
        acc = '0;
        p = b;
        for (int i = 0; i < 4; i++)
        begin
            if (m[i])
                acc = acc ^ p;
            p = xtime(p);
        end
        return acc;
    endfunction

    // Circulant matrix 14 11 13 9 per column
    function automatic state_t inv_mix_columns(input state_t s);
        state_t r;
        for (int c = 0; c < 4; c++)
            for (int row = 0; row < 4; row++)
                r[4*c + row] = gf_mul(s[4*c + row], 4'd14)
                             ^ gf_mul(s[4*c + (row + 1) % 4], 4'd11)
                             ^ gf_mul(s[4*c + (row + 2) % 4], 4'd13)
                             ^ gf_mul(s[4*c + (row + 3) % 4], 4'd9);
        return r;
    endfunction

    assign keyed = state ^ round_key;
    assign rnd.sub_done = sbox_done;

    // State register, one writer per command
    always_ff @(posedge clk)
    begin
        if (rnd.load)
            state <= in_data ^ round_key;
        else if (rnd.shift)
            state <= inv_shift_rows(state);
        else if (rnd.key_mix)
            state <= rnd.last ? keyed : inv_mix_columns(keyed);
        else if (sbox_valid)
            state[wr_idx] <= sbox_out;
    end

    // Byte walk, read index leads write index by one
    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            start <= 1'b0;
            rd_idx <= '0;
            wr_idx <= '0;
        end
        else
        begin
            start <= rnd.shift;
            // Runs 16 steps then wraps back to rest at zero
            if (start || rd_idx != '0)
                rd_idx <= rd_idx + 1'b1;
            if (sbox_valid)
                wr_idx <= wr_idx + 1'b1;
        end
    end

    aes_inv_sbox_serial u_sbox
    (
        .clk        (clk),
        .resetn     (resetn),
        .start      (start),
        .byte_in    (state[rd_idx]),
        .byte_out   (sbox_out),
        .byte_valid (sbox_valid),
        .done       (sbox_done)
    );

endmodule

// ==== rtl/aes_inv_sbox_serial.sv ====
//####################################################################
// Byte-serial inverse S-box with registered table
//####################################################################
`timescale 1ns/1ns
`include "aes_dec_config.svh"

module aes_inv_sbox_serial
(
    input  logic               clk,
    input  logic               resetn,
    input  logic               start,
    input  aes_dec_pkg::byte_t byte_in,
    output aes_dec_pkg::byte_t byte_out,
    output logic               byte_valid,
    output logic               done
);

    import aes_dec_pkg::*;

    localparam int cnt_w = $clog2(`AES_DEC_BYTES);

    // Inverse S-box, entry 0 first
    localparam byte_t [0:255] inv_sbox_tbl = {
        256'h52096ad53036a538bf40a39e81f3d7fb7ce339829b2fff87348e4344c4dee9cb,
        256'h547b9432a6c2233dee4c950b42fac34e082ea16628d924b2765ba2496d8bd125,
        256'h72f8f66486689816d4a45ccc5d65b6926c704850fdedb9da5e154657a78d9d84,
        256'h90d8ab008cbcd30af7e45805b8b34506d02c1e8fca3f0f02c1afbd0301138a6b,
        256'h3a9111414f67dcea97f2cfcef0b4e67396ac7422e7ad3585e2f937e81c75df6e,
        256'h47f11a711d29c5896fb7620eaa18be1bfc563e4bc6d279209adbc0fe78cd5af4,
        256'h1fdda8338807c731b11210592780ec5f60517fa919b54a0d2de57a9f93c99cef,
        256'ha0e03b4dae2af5b0c8ebbb3c83539961172b047eba77d626e169146355210c7d
    };

    logic busy;
    logic req;
    logic [cnt_w-1:0] req_cnt;

    // Start counts as the first request
    assign req = start || busy;

    always_ff @(posedge clk)
    begin
        if (req)
            byte_out <= inv_sbox_tbl[byte_in];
    end

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            busy <= 1'b0;
            req_cnt <= '0;
            byte_valid <= 1'b0;
            done <= 1'b0;
        end
        else
        begin
            byte_valid <= req;
            // Flag rides with the 16th result
            done <= req && (req_cnt == cnt_w'(`AES_DEC_BYTES - 1));
            if (req)
            begin
                req_cnt <= req_cnt + 1'b1;
                busy <= (req_cnt != cnt_w'(`AES_DEC_BYTES - 1));
            end
        end
    end

endmodule

// ==== rtl/aes_dec_decode.sv ====
//####################################################################
// Round sequencer FSM with input handshake and key-address countdown
//####################################################################
`timescale 1ns/1ns
`include "aes_dec_config.svh"

module aes_dec_decode
(
    input  logic                   clk,
    input  logic                   resetn,
    input  logic                   in_valid,
    output logic                   in_ready,
    output aes_dec_pkg::key_addr_t key_addr,
    input  logic                   full,
    output logic                   commit,
    aes_round_if.sequencer         rnd
);

    import aes_dec_pkg::*;

    round_phase_t phase;
    logic accept;

    // Only idle takes a new block
    assign in_ready = (phase == ph_idle);
    assign accept = in_valid && in_ready;

    // Hand the block over once result is free
    assign commit = (phase == ph_commit) && !full;

    // Commands follow the phase directly
    assign rnd.load = accept;
    assign rnd.shift = (phase == ph_shift);
    assign rnd.key_mix = (phase == ph_key_mix);
    assign rnd.last = (key_addr == '0);

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            phase <= ph_idle;
            key_addr <= key_addr_t'(`AES_DEC_ROUNDS);
        end
        else
        begin
            case (phase)
                ph_idle:
                begin
                    // Key 14 goes in with the load, next round uses 13
                    if (accept)
                    begin
                        phase <= ph_shift;
                        key_addr <= key_addr - 1'b1;
                    end
                end
                ph_shift:
                    phase <= ph_sub;
                ph_sub:
                begin
                    if (rnd.sub_done)
                        phase <= ph_key_mix;
                end
                ph_key_mix:
                begin
                    if (key_addr == '0)
                        phase <= ph_commit;
                    else
                    begin
                        phase <= ph_shift;
                        key_addr <= key_addr - 1'b1;
                    end
                end
                ph_commit:
                begin
                    // Stall here while the previous block is unread
                    if (!full)
                    begin
                        phase <= ph_idle;
                        key_addr <= key_addr_t'(`AES_DEC_ROUNDS);
                    end
                end
                default:
                    phase <= ph_idle;
            endcase
        end
    end

endmodule

// ==== rtl/aes_round_if.sv ====
//####################################################################
// Round command bundle between the sequencer and the datapath
//####################################################################
`timescale 1ns/1ns

interface aes_round_if;

    // Single-cycle command pulses
    logic load;
    logic shift;
    logic key_mix;
    // Final round, no mix columns
    logic last;
    // Last substituted byte written back
    logic sub_done;

    modport sequencer (output load, output shift, output key_mix, output last, input sub_done);

    modport datapath (input load, input shift, input key_mix, input last, output sub_done);

endinterface

// ==== rtl/aes_dec_pkg.sv ====
//####################################################################
// Byte, state and key-address types plus the sequencer phase encoding
//####################################################################
`include "aes_dec_config.svh"

package aes_dec_pkg;

    // One state byte
    typedef logic [7:0] byte_t;

    // Whole block, byte 0 sits in the top bits
    // Bytes run column by column, index = 4*column + row
    typedef byte_t [0:`AES_DEC_BYTES-1] state_t;

    // Round-key index, counts down to zero
    typedef logic [`AES_DEC_KADDR_W-1:0] key_addr_t;

    // Sequencer phases
    typedef enum logic [2:0] {
        ph_idle,
        ph_shift,
        ph_sub,
        ph_key_mix,
        ph_commit
    } round_phase_t;

endpackage

// ==== rtl/aes_dec_config.svh ====
//####################################################################
// Round count, block size and key-address width for the AES-256 decoder
//####################################################################
`ifndef AES_DEC_CONFIG_SVH
`define AES_DEC_CONFIG_SVH

// Cipher rounds for a 256-bit key
`define AES_DEC_ROUNDS 14
// Bytes in one block
`define AES_DEC_BYTES 16
// Wide enough for key index 0..14
`define AES_DEC_KADDR_W 4

`endif
